/* source/debug_pkg.sv */
package debug_pkg;

    // width of host words, instructions and registers
    localparam int DATA_W = 32;

    // commands handed from the decoder to the run controller
    typedef enum logic [2:0] {
        CMD_CONT   = 3'd0,  // run until END
        CMD_STEP   = 3'd1,  // enter step mode
        CMD_NEXT   = 3'd2,  // retire one instruction
        CMD_CANCEL = 3'd3   // leave step mode
    } cmd_e;

    // instruction bits 31..26
    typedef enum logic [5:0] {
        OP_ADD  = 6'b000000, // rd = rs + rt
        OP_ADDI = 6'b001000, // rt = rs + sext(imm)
        OP_END  = 6'b111111  // program end, core holds here
    } opcode_e;

    // fixed host messages, four ascii bytes each
    localparam logic [DATA_W-1:0] MSG_LOAD   = "\0lom";
    localparam logic [DATA_W-1:0] MSG_CONT   = "\0com";
    localparam logic [DATA_W-1:0] MSG_STEP   = "\0stm";
    localparam logic [DATA_W-1:0] MSG_NEXT   = "nxst";
    localparam logic [DATA_W-1:0] MSG_CANCEL = "clst";

    // last word of a program load, also decodes as OP_END
    localparam logic [DATA_W-1:0] END_MARKER = '1;

endpackage

/* source/instr_mem.sv */
`timescale 1ns/10ps

module instr_mem #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                           i_clk,
    input  logic                           i_we,
    input  logic [$clog2(IMEM_DEPTH)+1:0]  i_waddr,
    input  logic [debug_pkg::DATA_W-1:0]   i_wdata,
    input  logic [$clog2(IMEM_DEPTH)+1:0]  i_raddr,
    output logic [debug_pkg::DATA_W-1:0]   o_rdata
);

    import debug_pkg::*;

    localparam int WORD_AW = $clog2(IMEM_DEPTH);

    logic [DATA_W-1:0] mem [IMEM_DEPTH];

    // byte addresses in, low two bits dropped
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr[WORD_AW+1:2]] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr[WORD_AW+1:2]]; // same-cycle fetch

endmodule

/* source/mini_core.sv */
`timescale 1ns/10ps

module mini_core #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_halt,
    input  logic                           i_core_reset,
    input  logic [debug_pkg::DATA_W-1:0]   i_instr,
    input  logic [4:0]                     i_reg_sel,
    output logic [$clog2(IMEM_DEPTH)+1:0]  o_fetch_addr,
    output logic                           o_program_end,
    output logic [debug_pkg::DATA_W-1:0]   o_reg_data,
    output logic [debug_pkg::DATA_W-1:0]   o_pc
);

    import debug_pkg::*;

    localparam int ADDR_W = $clog2(IMEM_DEPTH) + 2;

    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] regs [32];

    opcode_e           op;
    logic [4:0]        rs;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [DATA_W-1:0] imm_ext;
    logic              retire;

    // instruction fields
    assign op      = opcode_e'(i_instr[31:26]);
    assign rs      = i_instr[25:21];
    assign rt      = i_instr[20:16];
    assign rd      = i_instr[15:11];
    assign imm_ext = {{(DATA_W-16){i_instr[15]}}, i_instr[15:0]};

    assign o_program_end = (op == OP_END);
    assign retire        = !i_halt && !o_program_end; // END holds the pc

    assign o_fetch_addr = pc[ADDR_W-1:0];
    assign o_pc         = pc;
    assign o_reg_data   = regs[i_reg_sel]; // debug read port

    always_ff @(posedge i_clk) begin
        if (i_reset || i_core_reset) begin
            pc <= '0;
        end else if (retire) begin
            pc <= pc + 4;
        end
    end

    // register 0 is cleared by reset and never written, so it reads zero
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire) begin
            case (op)
                OP_ADDI: begin
                    if (rt != 5'd0) begin
                        regs[rt] <= regs[rs] + imm_ext;
                    end
                end
                OP_ADD: begin
                    if (rd != 5'd0) begin
                        regs[rd] <= regs[rs] + regs[rt];
                    end
                end
                default: ; // unknown opcodes only move the pc
            endcase
        end
    end

endmodule

/* source/debug_cmd_decoder.sv */
`timescale 1ns/10ps

module debug_cmd_decoder #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_data_ready,
    input  logic [debug_pkg::DATA_W-1:0]   i_data,
    input  logic                           i_busy,
    output logic                           o_cmd_valid,
    output debug_pkg::cmd_e                o_cmd,
    output logic                           o_prog_loaded,
    output logic                           o_imem_we,
    output logic [$clog2(IMEM_DEPTH)+1:0]  o_imem_addr,
    output logic [debug_pkg::DATA_W-1:0]   o_imem_wdata
);

    import debug_pkg::*;

    typedef enum logic {
        DEC_CMD,  // words are matched against messages
        DEC_LOAD  // every word is an instruction
    } dec_state_e;

    dec_state_e state;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state         <= DEC_CMD;
            o_cmd_valid   <= 1'b0;
            o_prog_loaded <= 1'b0;
            o_imem_we     <= 1'b0;
            o_imem_addr   <= '0;
        end else begin
            o_cmd_valid   <= 1'b0;
            o_prog_loaded <= 1'b0;
            o_imem_we     <= 1'b0;

            // post-increment after each write, wrap to 0 after the marker
            if (o_imem_we) begin
                o_imem_addr <= o_prog_loaded ? '0 : o_imem_addr + 4;
            end

            if (i_data_ready) begin
                case (state)
                    DEC_CMD: begin
                        if (i_data == MSG_LOAD && !i_busy) begin
                            state       <= DEC_LOAD;
                            o_imem_addr <= '0;
                        end else if (i_data == MSG_CONT || i_data == MSG_STEP ||
                                     i_data == MSG_NEXT || i_data == MSG_CANCEL) begin
                            o_cmd_valid <= 1'b1;
                        end
                        // anything else is dropped
                    end
                    DEC_LOAD: begin
                        o_imem_we <= 1'b1;
                        if (i_data == END_MARKER) begin
                            o_prog_loaded <= 1'b1; // lines up with the marker write
                            state         <= DEC_CMD;
                        end
                    end
                    default: state <= DEC_CMD;
                endcase
            end
        end
    end

    // payload, only meaningful alongside its strobe
    always_ff @(posedge i_clk) begin
        if (i_data_ready) begin
            o_imem_wdata <= i_data;
            case (i_data)
                MSG_STEP:   o_cmd <= CMD_STEP;
                MSG_NEXT:   o_cmd <= CMD_NEXT;
                MSG_CANCEL: o_cmd <= CMD_CANCEL;
                default:    o_cmd <= CMD_CONT;
            endcase
        end
    end

endmodule

/* source/debug_controller.sv */
`timescale 1ns/10ps

module debug_controller (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_cmd_valid,
    input  debug_pkg::cmd_e  i_cmd,
    input  logic             i_prog_loaded,
    input  logic             i_program_end,
    input  logic             i_dump_done,
    output logic             o_busy,
    output logic             o_core_halt,
    output logic             o_core_reset,
    output logic             o_dump_start
);

    import debug_pkg::*;

    typedef enum logic [2:0] {
        IDLE,    // core halted, waiting for a mode command
        RUN,     // continuous execution
        ST_IDLE, // step mode, waiting for nxst or clst
        ST_EXEC, // halt released for one cycle
        DUMP     // dump unit streaming pc and registers
    } ctrl_state_e;

    ctrl_state_e state;
    logic        prog_ready; // a full program sits in memory
    logic        step_dump;  // DUMP goes back to step mode

    // load is refused outside idle
    assign o_busy = (state != IDLE);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= IDLE;
            prog_ready   <= 1'b0;
            step_dump    <= 1'b0;
            o_core_halt  <= 1'b1;
            o_core_reset <= 1'b0;
            o_dump_start <= 1'b0;
        end else begin
            o_core_reset <= 1'b0;
            o_dump_start <= 1'b0;

            if (i_prog_loaded) begin
                prog_ready <= 1'b1;
            end

            case (state)
                IDLE: begin
                    o_core_halt <= 1'b1;
                    if (i_cmd_valid && prog_ready) begin
                        case (i_cmd)
                            CMD_CONT: begin
                                o_core_halt <= 1'b0;
                                state       <= RUN;
                            end
                            CMD_STEP: state <= ST_IDLE;
                            default:  state <= IDLE; // nxst / clst mean nothing here
                        endcase
                    end
                end

                RUN: begin
                    // END reached, freeze the core and report
                    if (i_program_end) begin
                        o_core_halt  <= 1'b1;
                        o_dump_start <= 1'b1;
                        step_dump    <= 1'b0;
                        state        <= DUMP;
                    end
                end

                ST_IDLE: begin
                    if (i_cmd_valid) begin
                        case (i_cmd)
                            CMD_NEXT: begin
                                o_core_halt <= 1'b0;
                                state       <= ST_EXEC;
                            end
                            CMD_CANCEL: begin
                                o_core_reset <= 1'b1; // pc back to 0
                                state        <= IDLE;
                            end
                            default: state <= ST_IDLE;
                        endcase
                    end
                end

                ST_EXEC: begin
                    // the core retires one instruction on this edge
                    o_core_halt  <= 1'b1;
                    o_dump_start <= 1'b1;
                    step_dump    <= 1'b1;
                    state        <= DUMP;
                end

                DUMP: begin
                    if (i_dump_done) begin
                        if (step_dump) begin
                            state <= ST_IDLE;
                        end else begin
                            o_core_reset <= 1'b1; // registers survive, pc restarts
                            state        <= IDLE;
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/debug_dump_unit.sv */
`timescale 1ns/10ps

module debug_dump_unit (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_dump_start,
    input  logic [debug_pkg::DATA_W-1:0]  i_reg_data,
    input  logic [debug_pkg::DATA_W-1:0]  i_pc,
    output logic [4:0]                    o_reg_sel,
    output logic                          o_dump_valid,
    output logic [debug_pkg::DATA_W-1:0]  o_dump_data,
    output logic                          o_dump_done
);

    import debug_pkg::*;

    localparam logic [5:0] LAST_SLOT = 6'd32;

    logic [5:0]        slot;   // 0 is the pc, 1..32 are registers 0..31
    logic              active;
    logic              step;
    logic [DATA_W-1:0] word;

    assign step      = i_dump_start || active;
    assign o_reg_sel = slot[4:0] - 5'd1; // slot 32 wraps to register 31
    assign word      = (slot == '0) ? i_pc : i_reg_data;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            slot         <= '0;
            active       <= 1'b0;
            o_dump_valid <= 1'b0;
            o_dump_done  <= 1'b0;
        end else if (step) begin
            o_dump_valid <= 1'b1;
            o_dump_done  <= (slot == LAST_SLOT);
            active       <= (slot != LAST_SLOT);
            slot         <= (slot == LAST_SLOT) ? '0 : slot + 6'd1;
        end else begin
            o_dump_valid <= 1'b0;
            o_dump_done  <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (step) begin
            o_dump_data <= word;
        end
    end

endmodule

/* source/debug_top.sv */
`timescale 1ns/10ps

module debug_top #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_data_ready,
    input  logic [debug_pkg::DATA_W-1:0]  i_data,
    output logic                          o_dump_valid,
    output logic [debug_pkg::DATA_W-1:0]  o_dump_data,
    output logic                          o_halted
);

    import debug_pkg::*;

    localparam int ADDR_W = $clog2(IMEM_DEPTH) + 2;

    // decoder side
    logic              cmd_valid;
    cmd_e              cmd;
    logic              prog_loaded;
    logic              busy;
    logic              imem_we;
    logic [ADDR_W-1:0] imem_addr;
    logic [DATA_W-1:0] imem_wdata;

    // core side
    logic [ADDR_W-1:0] fetch_addr;
    logic [DATA_W-1:0] instr;
    logic              program_end;
    logic              core_reset;
    logic [4:0]        reg_sel;
    logic [DATA_W-1:0] reg_data;
    logic [DATA_W-1:0] pc;

    // dump handshake pulses
    logic              dump_start;
    logic              dump_done;

    debug_cmd_decoder #(.IMEM_DEPTH(IMEM_DEPTH)) u_decoder (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_data_ready(i_data_ready), .i_data(i_data), .i_busy(busy),
        .o_cmd_valid(cmd_valid), .o_cmd(cmd), .o_prog_loaded(prog_loaded),
        .o_imem_we(imem_we), .o_imem_addr(imem_addr), .o_imem_wdata(imem_wdata)
    );

    debug_controller u_controller (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_cmd_valid(cmd_valid), .i_cmd(cmd), .i_prog_loaded(prog_loaded),
        .i_program_end(program_end), .i_dump_done(dump_done),
        .o_busy(busy), .o_core_halt(o_halted), // halt level goes straight out
        .o_core_reset(core_reset), .o_dump_start(dump_start)
    );

    debug_dump_unit u_dump (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_dump_start(dump_start), .i_reg_data(reg_data), .i_pc(pc),
        .o_reg_sel(reg_sel), .o_dump_valid(o_dump_valid),
        .o_dump_data(o_dump_data), .o_dump_done(dump_done)
    );

    instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
        .i_clk(i_clk), .i_we(imem_we), .i_waddr(imem_addr), .i_wdata(imem_wdata),
        .i_raddr(fetch_addr), .o_rdata(instr)
    );

    mini_core #(.IMEM_DEPTH(IMEM_DEPTH)) u_core (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_halt(o_halted), .i_core_reset(core_reset),
        .i_instr(instr), .i_reg_sel(reg_sel),
        .o_fetch_addr(fetch_addr), .o_program_end(program_end),
        .o_reg_data(reg_data), .o_pc(pc)
    );

endmodule

/* verif/debug_checker.sv */
`timescale 1ns/10ps

module debug_checker #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_data_ready,
    input  logic [debug_pkg::DATA_W-1:0]  i_data,
    input  logic                          i_dump_valid,
    input  logic [debug_pkg::DATA_W-1:0]  i_dump_data,
    input  logic                          i_halted,
    input  logic [7:0]                    i_test_id,
    input  logic                          i_test_done,
    input  logic                          i_finish,
    output logic [31:0]                   o_dump_count,
    output logic [31:0]                   o_error_count
);

    import debug_pkg::*;

    localparam int AW         = $clog2(IMEM_DEPTH);
    localparam int DUMP_WORDS = 33;

    // reference model of the subsystem
    logic [DATA_W-1:0] ref_mem [IMEM_DEPTH];
    logic [DATA_W-1:0] ref_regs [32];
    logic [DATA_W-1:0] ref_pc;
    logic [DATA_W-1:0] ref_load_addr;
    logic              ref_loading;
    logic              ref_step;  // step mode
    logic              ref_ready; // a program was loaded

    logic [DATA_W-1:0] exp_q [$];  // 33 words per expected dump
    int                pending;    // dumps still owed by the DUT
    int                word_idx;   // slot inside the current dump
    logic              stray;
    logic              halt_bad;
    logic [31:0]       errors;
    logic [31:0]       errors_at_start;
    logic [31:0]       dumps;
    int                tests_run;
    int                tests_failed;

    assign o_dump_count  = dumps;
    assign o_error_count = errors;

    function automatic logic at_end();
        return ref_mem[ref_pc[AW+1:2]][31:26] == OP_END;
    endfunction

    // one instruction on the model, register 0 is never written
    function automatic void exec_instr(input logic [DATA_W-1:0] instr);
        logic [5:0]        op;
        logic [4:0]        rs;
        logic [4:0]        rt;
        logic [4:0]        rd;
        logic [DATA_W-1:0] imm;
        op  = instr[31:26];
        rs  = instr[25:21];
        rt  = instr[20:16];
        rd  = instr[15:11];
        imm = {{(DATA_W-16){instr[15]}}, instr[15:0]};
        if (op == OP_ADDI && rt != 5'd0) begin
            ref_regs[rt] = ref_regs[rs] + imm;
        end else if (op == OP_ADD && rd != 5'd0) begin
            ref_regs[rd] = ref_regs[rs] + ref_regs[rt];
        end
        ref_pc = ref_pc + 32'd4; // other opcodes only move the pc
    endfunction

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "commands before any load";
            8'd2:    return "continuous run";
            8'd3:    return "step and cancel";
            8'd4:    return "reload and run";
            8'd5:    return "step at end";
            default: return "unnamed";
        endcase
    endfunction

    task automatic push_dump();
        exp_q.push_back(ref_pc);
        for (int n = 0; n < 32; n++) begin
            exp_q.push_back(ref_regs[n]);
        end
        pending = pending + 1;
    endtask

    task automatic snoop_word(input logic [DATA_W-1:0] w);
        int guard;
        if (ref_loading) begin
            ref_mem[ref_load_addr[AW+1:2]] = w;
            ref_load_addr = ref_load_addr + 32'd4;
            if (w == END_MARKER) begin
                ref_loading   = 1'b0;
                ref_ready     = 1'b1;
                ref_load_addr = '0;
            end
        end else if (!ref_step) begin
            if (w == MSG_LOAD) begin
                ref_loading   = 1'b1;
                ref_load_addr = '0;
            end else if (w == MSG_CONT && ref_ready) begin
                guard = 0;
                while (!at_end() && guard < IMEM_DEPTH) begin
                    exec_instr(ref_mem[ref_pc[AW+1:2]]);
                    guard++;
                end
                push_dump();
                ref_pc = '0; // core reset after the dump
            end else if (w == MSG_STEP && ref_ready) begin
                ref_step = 1'b1;
            end
        end else if (w == MSG_NEXT) begin
            if (!at_end()) begin
                exec_instr(ref_mem[ref_pc[AW+1:2]]);
            end
            push_dump();
        end else if (w == MSG_CANCEL) begin
            ref_pc   = '0;
            ref_step = 1'b0;
        end
    endtask

    task automatic check_dump();
        logic [DATA_W-1:0] exp;
        if (i_dump_valid) begin
            if (word_idx == 0) begin
                stray = (pending == 0);
                if (stray) begin
                    $display("ERROR: a dump started while none was expected");
                    errors = errors + 32'd1;
                end
            end
            if (!stray) begin
                exp = exp_q.pop_front();
                if (i_dump_data !== exp) begin
                    if (word_idx == 0) begin
                        $display("FAILED o_dump_data slot pc: expected %h, actual %h",
                                 exp, i_dump_data);
                    end else begin
                        $display("FAILED o_dump_data slot r%0d: expected %h, actual %h",
                                 word_idx - 1, exp, i_dump_data);
                    end
                    errors = errors + 32'd1;
                end
            end
            word_idx++;
            if (word_idx == DUMP_WORDS) begin
                word_idx = 0;
                dumps    = dumps + 32'd1;
                if (!stray) pending = pending - 1;
            end
        end else if (word_idx != 0) begin
            $display("ERROR: dump stopped after %0d of %0d words", word_idx, DUMP_WORDS);
            errors = errors + 32'd1;
            if (!stray) begin
                for (int n = word_idx; n < DUMP_WORDS; n++) begin
                    exp = exp_q.pop_front(); // drop the words that never came
                end
                pending = pending - 1;
            end
            word_idx = 0;
        end
    endtask

    always @(posedge i_clk) begin
        if (i_reset) begin
            ref_pc        = '0;
            ref_load_addr = '0;
            ref_loading   = 1'b0;
            ref_step      = 1'b0;
            ref_ready     = 1'b0;
            for (int n = 0; n < 32; n++) begin
                ref_regs[n] = '0;
            end
            exp_q.delete();
            pending         = 0;
            word_idx        = 0;
            stray           = 1'b0;
            halt_bad        = 1'b0;
            errors          = '0;
            errors_at_start = '0;
            dumps           = '0;
            tests_run       = 0;
            tests_failed    = 0;
        end else begin
            // the core may only run while a dump is owed
            if (pending == 0 && word_idx == 0 && !i_halted) begin
                if (!halt_bad) begin
                    $display("ERROR: o_halted dropped with no run or step pending");
                    errors = errors + 32'd1;
                end
                halt_bad = 1'b1;
            end else begin
                halt_bad = 1'b0;
            end
            check_dump();
            if (i_data_ready) snoop_word(i_data);
            if (i_test_done) begin
                tests_run++;
                if (errors != errors_at_start) tests_failed++;
                $display("test %0d %s: %0d errors", i_test_id, test_name(i_test_id),
                         errors - errors_at_start);
                errors_at_start = errors;
            end
            if (i_finish) begin
                if (pending != 0 || word_idx != 0) begin
                    $display("ERROR: %0d expected dumps never arrived in full", pending);
                    errors = errors + 32'd1;
                end
                $display("tests run %0d, tests failed %0d, errors %0d",
                         tests_run, tests_failed, errors);
            end
        end
    end

endmodule

/* verif/tb_debug_top.sv */
`timescale 1ns/10ps

module tb_debug_top;

    import debug_pkg::*;

    localparam int IMEM_DEPTH     = 64;
    localparam int NUM_TESTS      = 5;
    localparam int PROG_LEN       = 10;
    localparam int MAX_STEPS      = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (PROG_LEN + 40) * MAX_STEPS * 2;

    logic              clk;
    logic              reset;
    logic              data_ready;
    logic [DATA_W-1:0] data;
    logic              dump_valid;
    logic [DATA_W-1:0] dump_data;
    logic              halted;
    logic [7:0]        test_id;
    logic              test_done;
    logic              finish_req;
    logic [31:0]       dump_count;
    logic [31:0]       error_count;
    logic [31:0]       lfsr;
    logic [31:0]       stray;
    int                cycle_count = 0;

    debug_top #(.IMEM_DEPTH(IMEM_DEPTH)) i_dut (
        .i_clk(clk), .i_reset(reset), .i_data_ready(data_ready), .i_data(data),
        .o_dump_valid(dump_valid), .o_dump_data(dump_data), .o_halted(halted)
    );

    debug_checker #(.IMEM_DEPTH(IMEM_DEPTH)) u_checker (
        .i_clk(clk), .i_reset(reset), .i_data_ready(data_ready), .i_data(data),
        .i_dump_valid(dump_valid), .i_dump_data(dump_data), .i_halted(halted),
        .i_test_id(test_id), .i_test_done(test_done), .i_finish(finish_req),
        .o_dump_count(dump_count), .o_error_count(error_count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, an expected dump never finished", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int n = 0; n < count; n++) begin
            value = {value[30:0], lfsr[0]}; // one step per bit
            lfsr  = next_lfsr(lfsr);
        end
    endtask

    // one strobe, then one quiet cycle
    task automatic send_word(input logic [31:0] word);
        data_ready = 1'b1;
        data       = word;
        @(posedge clk);
        #2;
        data_ready = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic send_and_wait(input logic [31:0] word);
        logic [31:0] target;
        target = dump_count + 32'd1;
        send_word(word);
        while (dump_count < target) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk);
        #2;
    endtask

    task automatic load_program(input int len);
        logic [31:0] bits;
        logic [31:0] instr;
        send_word(MSG_LOAD);
        for (int n = 0; n < len; n++) begin
            random_bits(1, bits);
            instr[31:26] = bits[0] ? OP_ADD : OP_ADDI;
            random_bits(26, bits); // register fields and immediate
            instr[25:0] = bits[25:0];
            send_word(instr);
        end
        send_word(END_MARKER);
    endtask

    task automatic end_test(input logic [7:0] id);
        test_id   = id;
        test_done = 1'b1;
        @(posedge clk);
        #2;
        test_done = 1'b0;
    endtask

    initial begin
        reset      = 1'b1;
        data_ready = 1'b0;
        data       = '0;
        test_id    = '0;
        test_done  = 1'b0;
        finish_req = 1'b0;
        lfsr       = 32'h46d4;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        idle_cycles(2);

        // nothing loaded yet, so none of this may start the core
        send_word(MSG_CONT);
        send_word(MSG_STEP);
        send_word(MSG_NEXT);
        random_bits(32, stray);
        send_word(stray);
        send_word(MSG_CANCEL);
        idle_cycles(40);
        end_test(8'd1);

        load_program(PROG_LEN);
        send_and_wait(MSG_CONT);
        idle_cycles(5);
        end_test(8'd2);

        send_word(MSG_STEP);
        repeat (4) send_and_wait(MSG_NEXT);
        send_word(MSG_CANCEL);
        send_word(MSG_NEXT); // back in idle, so no step may follow
        idle_cycles(40); // o_halted must stay high here
        end_test(8'd3);

        load_program(PROG_LEN);
        send_and_wait(MSG_CONT);
        idle_cycles(5);
        end_test(8'd4);

        load_program(3);
        send_word(MSG_STEP);
        repeat (MAX_STEPS) send_and_wait(MSG_NEXT); // last two land on END
        send_word(MSG_CANCEL);
        idle_cycles(10);
        end_test(8'd5);

        finish_req = 1'b1;
        @(posedge clk);
        #2;
        finish_req = 1'b0;
        idle_cycles(1);
        if (error_count == 32'd0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* build.f */
source/debug_pkg.sv
source/instr_mem.sv
source/mini_core.sv
source/debug_cmd_decoder.sv
source/debug_controller.sv
source/debug_dump_unit.sv
source/debug_top.sv
verif/debug_checker.sv
verif/tb_debug_top.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing -j 0 --top-module tb_debug_top -f build.f -o tb_debug_top \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_debug_top)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
